// File: src.f
+incdir+include
hw/matmul_pkg.sv
hw/job_sequencer.sv
hw/tile_fetch.sv
hw/block_mac.sv
hw/result_writer.sv
hw/matmul_top.sv
sim/tb_matmul.sv

// File: run.sh
#!/bin/sh
# build and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_matmul -o tb_matmul
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_matmul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

// File: sim/tb_matmul.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module tb_matmul
    import matmul_pkg::*;
();

    localparam int          MEM_DEPTH = 4096;
    localparam int          N_JOBS    = 8;
    localparam logic [31:0] SEED      = 32'h68f30ef2;

    logic  clk;
    logic  reset;
    logic  start_req;
    dim_t  rows;
    dim_t  mid;
    dim_t  cols;
    logic  start_ack;
    addr_t addr_a;
    addr_t addr_b;
    logic  we_a;
    logic  we_b;
    data_t wdata_a;
    data_t wdata_b;
    data_t rdata_a = '0;
    data_t rdata_b = '0;

    data_t       mem [MEM_DEPTH];
    data_t       preload [MEM_DEPTH];
    logic        reload;
    logic [31:0] rng;
    int          cur_rows;
    int          cur_mid;
    int          cur_cols;
    logic        check_req;
    logic        check_ack;
    int          cmp_errs;
    int          reset_errs;
    int          pass_count;
    int          fail_count;

    // rows, mid, cols, kind (0 random, 1 identity B, 2 near 2^31)
    int job_rows [N_JOBS] = '{2, 4, 2, 6, 4, 4, 4, 2};
    int job_mid  [N_JOBS] = '{2, 6, 4, 2, 4, 4, 2, 6};
    int job_cols [N_JOBS] = '{2, 2, 8, 4, 4, 4, 6, 4};
    int job_kind [N_JOBS] = '{0, 0, 0, 0, 1, 2, 0, 0};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    matmul_top UUT (
        .clk(clk), .reset(reset), .start_req(start_req),
        .rows(rows), .mid(mid), .cols(cols), .start_ack(start_ack),
        .addr_a(addr_a), .addr_b(addr_b), .we_a(we_a), .we_b(we_b),
        .wdata_a(wdata_a), .wdata_b(wdata_b), .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    ////////////////////////////////////////
    // dual-port memory, one cycle read
    ////////////////////////////////////////

    always @(posedge clk) begin
        int n;
        if (reload) begin
            for (n = 0; n < MEM_DEPTH; n++) begin
                mem[addr_t'(n)] <= preload[addr_t'(n)];
            end
        end else begin
            if (we_a) mem[addr_a] <= wdata_a;
            if (we_b) mem[addr_b] <= wdata_b;
        end
        rdata_a <= mem[addr_a];
        rdata_b <= mem[addr_b];
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // background word, unique per address
    function automatic data_t fill_word(input int addr);
        addr_t a;
        a = addr_t'(addr);
        return {8'ha5, a, ~a};
    endfunction

    function automatic data_t matmul_ref(input int r, input int c);
        data_t acc;
        int    k;
        int    b_base;
        acc    = '0;
        b_base = `MATMUL_A_BASE + cur_rows * cur_mid;
        for (k = 0; k < cur_mid; k++) begin
            acc = acc + preload[addr_t'(`MATMUL_A_BASE + r * cur_mid + k)]
                      * preload[addr_t'(b_base + k * cur_cols + c)];
        end
        return acc;
    endfunction

    // C region from the reference, everything else untouched
    function automatic data_t expected_word(input int addr);
        int c_base;
        int idx;
        c_base = `MATMUL_A_BASE + cur_rows * cur_mid + cur_mid * cur_cols;
        idx    = addr - c_base;
        if (idx >= 0 && idx < cur_rows * cur_cols) begin
            return matmul_ref(idx / cur_cols, idx % cur_cols);
        end
        return preload[addr_t'(addr)];
    endfunction

    task automatic load_job(input int n);
        int addr;
        int idx;
        int b_base;
        int kind;
        cur_rows = job_rows[3'(n)];
        cur_mid  = job_mid[3'(n)];
        cur_cols = job_cols[3'(n)];
        kind     = job_kind[3'(n)];
        b_base   = `MATMUL_A_BASE + cur_rows * cur_mid;
        for (addr = 0; addr < MEM_DEPTH; addr++) begin
            preload[addr_t'(addr)] = fill_word(addr);
        end
        for (idx = 0; idx < cur_rows * cur_mid; idx++) begin
            rng = xorshift32(rng);
            preload[addr_t'(`MATMUL_A_BASE + idx)] =
                (kind == 2) ? 32'h7fff_ff00 + (rng & 32'h1ff) : rng;
        end
        for (idx = 0; idx < cur_mid * cur_cols; idx++) begin
            rng = xorshift32(rng);
            if (kind == 1) begin
                preload[addr_t'(b_base + idx)] = (idx / cur_cols == idx % cur_cols) ? 1 : 0;
            end else begin
                preload[addr_t'(b_base + idx)] =
                    (kind == 2) ? 32'h7fff_ff00 + (rng & 32'h1ff) : rng;
            end
        end
    endtask

    task automatic run_job(input int n, input int prior_errs);
        int errs;
        errs = prior_errs;
        load_job(n);
        rows   = dim_t'(cur_rows);
        mid    = dim_t'(cur_mid);
        cols   = dim_t'(cur_cols);
        reload = 1'b1;
        @(negedge clk);
        reload    = 1'b0;
        start_req = 1'b1;
        while (start_ack !== 1'b1) @(negedge clk);
        check_req = 1'b1;
        wait (check_ack);
        check_req = 1'b0;
        wait (!check_ack);
        errs = errs + cmp_errs;
        // ack has to stay up until the host lets go
        @(negedge clk);
        if (start_ack !== 1'b1) begin
            $display("[FAIL] %0t: start_ack fell while start_req was still high", $time);
            errs++;
        end
        start_req = 1'b0;
        while (start_ack !== 1'b0) @(negedge clk);
        if (errs == 0) begin
            pass_count++;
            $display("test %0d (%0dx%0dx%0d): ok", n, cur_rows, cur_mid, cur_cols);
        end else begin
            fail_count++;
            $display("test %0d (%0dx%0dx%0d): %0d errors", n, cur_rows, cur_mid, cur_cols, errs);
        end
    endtask

    ////////////////////////////////////////
    // compare process
    ////////////////////////////////////////

    initial begin
        int addr;
        check_ack = 1'b0;
        cmp_errs  = 0;
        forever begin
            wait (check_req);
            cmp_errs = 0;
            for (addr = 0; addr < MEM_DEPTH; addr++) begin
                if (mem[addr_t'(addr)] !== expected_word(addr)) begin
                    cmp_errs++;
                    $display("[FAIL] %0t: addr %0d expected %h found %h", $time, addr,
                             expected_word(addr), mem[addr_t'(addr)]);
                end
            end
            check_ack = 1'b1;
            wait (!check_req);
            check_ack = 1'b0;
        end
    end

    initial begin
        int n;
        reset      = 1'b0;
        start_req  = 1'b0;
        rows       = dim_t'(2);
        mid        = dim_t'(2);
        cols       = dim_t'(2);
        reload     = 1'b0;
        check_req  = 1'b0;
        rng        = SEED;
        reset_errs = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        if (start_ack !== 1'b0 || we_a !== 1'b0 || we_b !== 1'b0) begin
            $display("[FAIL] %0t: outputs not idle after reset, start_ack=%b we_a=%b we_b=%b",
                     $time, start_ack, we_a, we_b);
            reset_errs = 1;
        end
        run_job(0, reset_errs);
        for (n = 1; n < N_JOBS; n++) begin
            run_job(n, 0);
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, scaled by the work in each job
    initial begin
        int n;
        int limit;
        limit = 1000;
        for (n = 0; n < N_JOBS; n++) begin
            limit = limit + 20 * job_rows[3'(n)] * job_mid[3'(n)] * job_cols[3'(n)];
        end
        repeat (limit) @(posedge clk);
        $display("error: run timed out waiting for start_ack");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: hw/matmul_top.sv
`timescale 1ns/1ps

module matmul_top
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start_req,
    input  dim_t  rows,
    input  dim_t  mid,
    input  dim_t  cols,
    output logic  start_ack,
    output addr_t addr_a,
    output addr_t addr_b,
    output logic  we_a,
    output logic  we_b,
    output data_t wdata_a,
    output data_t wdata_b,
    input  data_t rdata_a,
    input  data_t rdata_b
);

    ////////////////////////////////////////
    // stage hand-off wires
    ////////////////////////////////////////

    logic  treq, tack, req_first, req_last;
    addr_t req_a_addr, req_b_addr, req_c_addr;
    logic  freq, fack, tile_first, tile_last;
    data_t a11, a12, a21, a22, b11, b12, b21, b22;
    addr_t tile_c_addr, rd_addr_a, rd_addr_b;
    logic  rreq, rack, tile_written, ports_busy;
    data_t c11, c12, c21, c22;
    addr_t res_c_addr;

    job_sequencer u_seq (
        .clk(clk), .reset(reset), .start_req(start_req),
        .rows(rows), .mid(mid), .cols(cols),
        .tack(tack), .tile_written(tile_written),
        .start_ack(start_ack), .treq(treq), .first(req_first), .last(req_last),
        .a_addr(req_a_addr), .b_addr(req_b_addr), .c_addr(req_c_addr)
    );

    tile_fetch u_fetch (
        .clk(clk), .reset(reset), .treq(treq),
        .a_addr(req_a_addr), .b_addr(req_b_addr), .c_addr(req_c_addr),
        .first(req_first), .last(req_last), .mid(mid), .cols(cols),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .ports_busy(ports_busy), .fack(fack),
        .tack(tack), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .a11(a11), .a12(a12), .a21(a21), .a22(a22),
        .b11(b11), .b12(b12), .b21(b21), .b22(b22),
        .tile_c_addr(tile_c_addr), .tile_first(tile_first), .tile_last(tile_last),
        .freq(freq)
    );

    block_mac u_mac (
        .clk(clk), .reset(reset), .freq(freq),
        .a11(a11), .a12(a12), .a21(a21), .a22(a22),
        .b11(b11), .b12(b12), .b21(b21), .b22(b22),
        .tile_c_addr(tile_c_addr), .tile_first(tile_first), .tile_last(tile_last),
        .rack(rack), .fack(fack),
        .c11(c11), .c12(c12), .c21(c21), .c22(c22),
        .res_c_addr(res_c_addr), .rreq(rreq)
    );

    result_writer u_writer (
        .clk(clk), .reset(reset), .rreq(rreq),
        .c11(c11), .c12(c12), .c21(c21), .c22(c22),
        .res_c_addr(res_c_addr), .cols(cols),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rack(rack), .tile_written(tile_written), .ports_busy(ports_busy),
        .addr_a(addr_a), .addr_b(addr_b), .we_a(we_a), .we_b(we_b),
        .wdata_a(wdata_a), .wdata_b(wdata_b)
    );

endmodule

// File: hw/result_writer.sv
`timescale 1ns/1ps

module result_writer
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rreq,
    input  data_t c11,
    input  data_t c12,
    input  data_t c21,
    input  data_t c22,
    input  addr_t res_c_addr,
    input  dim_t  cols,
    input  addr_t rd_addr_a,
    input  addr_t rd_addr_b,
    output logic  rack,
    output logic  tile_written,
    output logic  ports_busy,
    output addr_t addr_a,
    output addr_t addr_b,
    output logic  we_a,
    output logic  we_b,
    output data_t wdata_a,
    output data_t wdata_b
);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_PREP,
        WR_ROW0,
        WR_ROW1,
        WR_ACK
    } wr_state_e;

    wr_state_e state;
    addr_t     row_addr;
    logic      writing;

    assign writing    = (state == WR_ROW0) || (state == WR_ROW1);
    // prep cycle keeps fetch from starting a read that would collide
    assign ports_busy = (state == WR_PREP) || writing;
    assign rack       = (state == WR_ACK);

    // second row sits one C row further down
    assign row_addr = (state == WR_ROW1) ? res_c_addr + addr_t'(cols) : res_c_addr;

    assign addr_a  = writing ? row_addr : rd_addr_a;
    assign addr_b  = writing ? row_addr + addr_t'(1) : rd_addr_b;
    assign we_a    = writing;
    assign we_b    = writing;
    assign wdata_a = (state == WR_ROW1) ? c21 : c11;
    assign wdata_b = (state == WR_ROW1) ? c22 : c12;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= WR_IDLE;
            tile_written <= 1'b0;
        end else begin
            tile_written <= 1'b0;
            case (state)
                WR_IDLE: if (rreq) state <= WR_PREP;
                WR_PREP: state <= WR_ROW0;
                WR_ROW0: state <= WR_ROW1;
                WR_ROW1: begin
                    tile_written <= 1'b1;
                    state        <= WR_ACK;
                end
                default: if (!rreq) state <= WR_IDLE;
            endcase
        end
    end

endmodule

// File: hw/block_mac.sv
`timescale 1ns/1ps

module block_mac
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  freq,
    input  data_t a11,
    input  data_t a12,
    input  data_t a21,
    input  data_t a22,
    input  data_t b11,
    input  data_t b12,
    input  data_t b21,
    input  data_t b22,
    input  addr_t tile_c_addr,
    input  logic  tile_first,
    input  logic  tile_last,
    input  logic  rack,
    output logic  fack,
    output data_t c11,
    output data_t c12,
    output data_t c21,
    output data_t c22,
    output addr_t res_c_addr,
    output logic  rreq
);

    data_t p11;
    data_t p12;
    data_t p21;
    data_t p22;
    data_t s11;
    data_t s12;
    data_t s21;
    data_t s22;
    logic  accept;

    // 2x2 tile product, all arithmetic wraps at 32 bits
    assign p11 = a11 * b11 + a12 * b21;
    assign p12 = a11 * b12 + a12 * b22;
    assign p21 = a21 * b11 + a22 * b21;
    assign p22 = a21 * b12 + a22 * b22;

    assign s11 = tile_first ? p11 : c11 + p11;
    assign s12 = tile_first ? p12 : c12 + p12;
    assign s21 = tile_first ? p21 : c21 + p21;
    assign s22 = tile_first ? p22 : c22 + p22;

    // hold off the next tile until the writer handshake has closed
    assign accept = freq && !fack && !rreq && !rack;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fack <= 1'b0;
            rreq <= 1'b0;
        end else begin
            if (accept) begin
                fack <= 1'b1;
                if (tile_last) begin
                    rreq <= 1'b1;
                end
            end else if (fack && !freq) begin
                fack <= 1'b0;
            end
            if (rreq && rack) begin
                rreq <= 1'b0;
            end
        end
    end

    // accumulators double as the result held for the writer
    always_ff @(posedge clk) begin
        if (accept) begin
            c11 <= s11;
            c12 <= s12;
            c21 <= s21;
            c22 <= s22;
            if (tile_last) begin
                res_c_addr <= tile_c_addr;
            end
        end
    end

endmodule

// File: hw/tile_fetch.sv
`timescale 1ns/1ps

module tile_fetch
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  treq,
    input  addr_t a_addr,
    input  addr_t b_addr,
    input  addr_t c_addr,
    input  logic  first,
    input  logic  last,
    input  dim_t  mid,
    input  dim_t  cols,
    input  data_t rdata_a,
    input  data_t rdata_b,
    input  logic  ports_busy,
    input  logic  fack,
    output logic  tack,
    output addr_t rd_addr_a,
    output addr_t rd_addr_b,
    output data_t a11,
    output data_t a12,
    output data_t a21,
    output data_t a22,
    output data_t b11,
    output data_t b12,
    output data_t b21,
    output data_t b22,
    output addr_t tile_c_addr,
    output logic  tile_first,
    output logic  tile_last,
    output logic  freq
);

    fetch_state_e state;
    addr_t        a_ptr;
    addr_t        b_ptr;
    logic         accept;
    logic         issue;
    logic         issued_q;

    assign accept = (state == FETCH_IDLE) && treq && !tack && !fack;
    // no read while the writer owns the ports
    assign issue  = (state inside {FETCH_READ0, FETCH_READ1, FETCH_READ2, FETCH_READ3})
                    && !ports_busy;
    assign freq   = (state == FETCH_HAND);

    // row strides are mid for A and cols for B
    always_comb begin
        rd_addr_a = a_ptr;
        rd_addr_b = b_ptr;
        case (state)
            FETCH_READ1: begin
                rd_addr_a = a_ptr + addr_t'(1);
                rd_addr_b = b_ptr + addr_t'(1);
            end
            FETCH_READ2: begin
                rd_addr_a = a_ptr + addr_t'(mid);
                rd_addr_b = b_ptr + addr_t'(cols);
            end
            FETCH_READ3: begin
                rd_addr_a = a_ptr + addr_t'(mid) + addr_t'(1);
                rd_addr_b = b_ptr + addr_t'(cols) + addr_t'(1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= FETCH_IDLE;
            tack     <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            issued_q <= issue;
            if (tack && !treq) begin
                tack <= 1'b0;
            end
            case (state)
                FETCH_IDLE: begin
                    if (accept) begin
                        tack  <= 1'b1;
                        state <= FETCH_READ0;
                    end
                end
                FETCH_READ0: if (issue) state <= FETCH_READ1;
                FETCH_READ1: if (issue) state <= FETCH_READ2;
                FETCH_READ2: if (issue) state <= FETCH_READ3;
                FETCH_READ3: if (issue) state <= FETCH_LAST;
                FETCH_LAST:  state <= FETCH_HAND;
                default:     if (fack) state <= FETCH_IDLE;
            endcase
        end
    end

    // read data lands one cycle after its address, one state later
    always_ff @(posedge clk) begin
        if (accept) begin
            a_ptr       <= a_addr;
            b_ptr       <= b_addr;
            tile_c_addr <= c_addr;
            tile_first  <= first;
            tile_last   <= last;
        end
        if (issued_q) begin
            case (state)
                FETCH_READ1: begin
                    a11 <= rdata_a;
                    b11 <= rdata_b;
                end
                FETCH_READ2: begin
                    a12 <= rdata_a;
                    b12 <= rdata_b;
                end
                FETCH_READ3: begin
                    a21 <= rdata_a;
                    b21 <= rdata_b;
                end
                FETCH_LAST: begin
                    a22 <= rdata_a;
                    b22 <= rdata_b;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hw/job_sequencer.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module job_sequencer
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start_req,
    input  dim_t  rows,
    input  dim_t  mid,
    input  dim_t  cols,
    input  logic  tack,
    input  logic  tile_written,
    output logic  start_ack,
    output logic  treq,
    output logic  first,
    output logic  last,
    output addr_t a_addr,
    output addr_t b_addr,
    output addr_t c_addr
);

    localparam int CNT_W = 2 * `MATMUL_DIM_WIDTH;

    seq_state_e       state;
    dim_t             i;
    dim_t             j;
    dim_t             k;
    logic [CNT_W-1:0] issued_cnt;
    logic [CNT_W-1:0] written_cnt;
    addr_t            a_row;
    addr_t            b_start;
    addr_t            c_start;
    logic             start;
    logic             advance;
    logic             j_wrap;
    logic             i_wrap;

    // dimensions are held by the host for the whole job
    assign b_start = addr_t'(`MATMUL_A_BASE) + addr_t'(rows) * addr_t'(mid);
    assign c_start = b_start + addr_t'(mid) * addr_t'(cols);

    assign first   = (k == '0);
    assign last    = (k == mid - dim_t'(2));
    assign j_wrap  = (j == cols - dim_t'(2));
    assign i_wrap  = (i == rows - dim_t'(2));
    assign start   = (state == SEQ_IDLE) && start_req;
    assign advance = (state == SEQ_ISSUE) && treq && tack;

    ////////////////////////////////////////
    // loop control
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= SEQ_IDLE;
            treq        <= 1'b0;
            start_ack   <= 1'b0;
            i           <= '0;
            j           <= '0;
            k           <= '0;
            issued_cnt  <= '0;
            written_cnt <= '0;
        end else begin
            if (tile_written) begin
                written_cnt <= written_cnt + CNT_W'(1);
            end
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        i           <= '0;
                        j           <= '0;
                        k           <= '0;
                        issued_cnt  <= '0;
                        written_cnt <= '0;
                        state       <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    if (!treq && !tack) begin
                        treq <= 1'b1;
                    end else if (advance) begin
                        treq <= 1'b0;
                        if (!last) begin
                            k <= k + dim_t'(2);
                        end else begin
                            issued_cnt <= issued_cnt + CNT_W'(1);
                            k <= '0;
                            if (!j_wrap) begin
                                j <= j + dim_t'(2);
                            end else begin
                                j <= '0;
                                if (!i_wrap) begin
                                    i <= i + dim_t'(2);
                                end else begin
                                    state <= SEQ_DRAIN;
                                end
                            end
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // all C tiles issued, wait for the writer to catch up
                    if (written_cnt == issued_cnt) begin
                        start_ack <= 1'b1;
                        state     <= SEQ_DONE;
                    end
                end
                default: begin
                    if (!start_req) begin
                        start_ack <= 1'b0;
                        state     <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // tile base addresses, stepped alongside k, j and i
    always_ff @(posedge clk) begin
        if (start) begin
            a_row  <= addr_t'(`MATMUL_A_BASE);
            a_addr <= addr_t'(`MATMUL_A_BASE);
            b_addr <= b_start;
            c_addr <= c_start;
        end else if (advance) begin
            if (!last) begin
                a_addr <= a_addr + addr_t'(2);
                b_addr <= b_addr + (addr_t'(cols) << 1);
            end else if (!j_wrap) begin
                a_addr <= a_row;
                b_addr <= b_start + addr_t'(j) + addr_t'(2);
                c_addr <= c_addr + addr_t'(2);
            end else begin
                a_row  <= a_row + (addr_t'(mid) << 1);
                a_addr <= a_row + (addr_t'(mid) << 1);
                b_addr <= b_start;
                c_addr <= c_addr + addr_t'(2) + addr_t'(cols);
            end
        end
    end

endmodule

// File: hw/matmul_pkg.sv
package matmul_pkg;

`include "matmul_config.svh"

    typedef logic [`MATMUL_DATA_WIDTH-1:0] data_t;
    typedef logic [`MATMUL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MATMUL_DIM_WIDTH-1:0]  dim_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_e;

    // one read state per tile corner
    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_READ0,
        FETCH_READ1,
        FETCH_READ2,
        FETCH_READ3,
        FETCH_LAST,
        FETCH_HAND
    } fetch_state_e;

endpackage

// File: include/matmul_config.svh
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// element and memory widths
`define MATMUL_DATA_WIDTH 32
`define MATMUL_ADDR_WIDTH 12

// dimension limits
`define MATMUL_MAX_LEN    100
`define MATMUL_DIM_WIDTH  7

// A starts here, B and C follow directly
`define MATMUL_A_BASE     2

`endif
